//--- bench/icache_cases.txt
// Columns: fetch byte address (hex), expected miss flag (1 = line refilled)
// Cases run in order, the cache state carries over between lines
// Set 0, first fetch after reset starts mid-line
00000024 1
00000024 0
00000000 0
0000003c 0
00000020 0
00000028 0
// Set 1, burst starts at the last word and wraps
0000487c 1
00004840 0
00004860 0
// Second line in set 0, first one stays
00abc010 1
00000004 0
00abc03c 0
// Top of the address space, set 14
fffff380 1
fffff3bc 0
// Set 3, lines A B C D fill all four ways
000004c8 1
000008c0 1
00000cf4 1
000010c4 1
// Touch A C D, leaving B least recently used
000004c0 0
00000cc0 0
000010fc 0
// Line E evicts B
000014c0 1
000004c4 0
00000cc8 0
000010c0 0
000014cc 0
// B was evicted
000008c0 1
000014c0 0

//--- bench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int ok_timeout = 300;
  localparam int max_cases  = 64;

  logic        clk;
  logic        rst;
  logic        req;
  logic [31:0] insaddr;
  logic [31:0] ins;
  logic        ok;
  logic        miss;
  logic        sen;
  logic [31:0] addr;
  logic        data_ok = 1'b0;
  logic [31:0] sdata = '0;

  logic [31:0] case_mem [0:2*max_cases-1];
  logic [31:0] rng_state;
  logic [4:0]  beats_sent;
  logic [3:0]  beat_word;
  int          gap_left;
  int          beat_total;
  int          num_cases;

  icache_top dut (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .insaddr (insaddr),
    .ins     (ins),
    .ok      (ok),
    .miss    (miss),
    .sen     (sen),
    .addr    (addr),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  always #5 clk = ~clk;

  // Memory word is its own address XORed with a fixed pattern
  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return {byte_addr[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      $display("Fail %s exp %h got %h", name, exp, got);
      $display("FAIL: see errors above");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Memory model with wrapping burst and random gaps

  always @(negedge clk)
  begin
    if (rst || !sen)
    begin
      data_ok    <= 1'b0;
      beats_sent = '0;
      gap_left   = 0;
    end
    else if (beats_sent < 5'd16 && gap_left == 0)
    begin
      beat_word = addr[5:2] + beats_sent[3:0];
      data_ok   <= 1'b1;
      sdata     <= mem_word({addr[31:6], beat_word, 2'b00});
      beats_sent = beats_sent + 1'b1;
      beat_total = beat_total + 1;
      rng_state  = next_rand(rng_state);
      gap_left   = rng_state[1:0];
    end
    else
    begin
      data_ok <= 1'b0;
      if (gap_left > 0)
        gap_left = gap_left - 1;
    end
  end

  //////////////////////////////////////////////////
  // One fetch starting on a falling edge

  task automatic fetch_word(input logic [31:0] fetch_addr, input logic exp_miss);
    int          cycles;
    logic        saw_sen;
    logic        saw_miss;
    logic        got_ok;
    logic [31:0] got_ins;
    cycles     = 0;
    saw_sen    = 1'b0;
    saw_miss   = 1'b0;
    got_ok     = 1'b0;
    got_ins    = '0;
    beat_total = 0;
    req        = 1'b1;
    insaddr    = fetch_addr;
    while (!got_ok && cycles < ok_timeout)
    begin
      @(negedge clk);
      cycles++;
      // Burst address is the missed word
      if (sen && !saw_sen)
        check_value("addr", {fetch_addr[31:2], 2'b00}, addr);
      saw_sen  = saw_sen | sen;
      saw_miss = saw_miss | miss;
      if (ok)
      begin
        got_ok  = 1'b1;
        got_ins = ins;
      end
    end
    if (!got_ok)
    begin
      $display("Timed out after %0d cycles waiting for ok on fetch of %h", cycles, fetch_addr);
      $display("FAIL: see errors above");
      $fatal(1, "Fetch never completed");
    end
    else
    begin
      req = 1'b0;
      check_value("ins", mem_word(fetch_addr), got_ins);
      check_value("miss", {31'd0, exp_miss}, {31'd0, saw_miss});
      check_value("sen", {31'd0, exp_miss}, {31'd0, saw_sen});
      check_value("beats", exp_miss ? 32'd16 : 32'd0, beat_total);
      @(negedge clk);
      // ok is a single pulse
      check_value("ok", 32'd0, {31'd0, ok});
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    req        = 1'b0;
    insaddr    = '0;
    rng_state  = 32'h1c1db06a;
    beat_total = 0;
    num_cases  = 0;

    $readmemh("bench/icache_cases.txt", case_mem);
    while (num_cases < max_cases && !$isunknown(case_mem[2*num_cases]))
      num_cases++;

    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("ok", 32'd0, {31'd0, ok});
    check_value("sen", 32'd0, {31'd0, sen});
    check_value("miss", 32'd0, {31'd0, miss});

    if (num_cases == 0)
    begin
      $display("No fetch cases could be read from bench/icache_cases.txt");
      $display("FAIL: see errors above");
      $fatal(1, "Empty case list");
    end
    else
    begin
      for (int i = 0; i < num_cases; i++)
        fetch_word(case_mem[2*i], case_mem[2*i+1][0]);
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_way.sv
hw/lru_ages.sv
hw/refill_unit.sv
hw/icache_ctrl.sv
hw/icache_top.sv
bench/icache_tb.sv

//--- hw/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Cache geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        16
`define ICACHE_LINE_WORDS  16

// Fetch address fields
`define ICACHE_TAG_W       22
`define ICACHE_TAG_LSB     10
`define ICACHE_SET_W       4
`define ICACHE_SET_LSB     6
`define ICACHE_WORD_W      4
`define ICACHE_WORD_LSB    2

// Replacement ages
`define ICACHE_AGE_W       2

`endif

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  input  word_t                   insaddr,
  output set_t                    rd_set,
  input  tag_t                    tags [`ICACHE_WAYS],
  input  logic [`ICACHE_WAYS-1:0] valids,
  input  word_t                   lines [`ICACHE_WAYS][`ICACHE_LINE_WORDS],
  input  way_t                    victim,
  output logic                    touch,
  output way_t                    touch_way,
  output logic                    fill_start,
  output word_t                   miss_addr,
  input  logic                    fill_done,
  output logic                    ok,
  output word_t                   ins,
  output logic                    miss
);

  ctrl_state_e             state;
  ctrl_state_e             state_next;
  logic [`ICACHE_WAYS-1:0] hit_vec;
  logic                    hit;
  way_t                    hit_way;
  tag_t                    req_tag;
  word_idx_t               word_sel;

  assign rd_set   = insaddr[`ICACHE_SET_LSB +: `ICACHE_SET_W];
  assign req_tag  = insaddr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
  assign word_sel = insaddr[`ICACHE_WORD_LSB +: `ICACHE_WORD_W];

  // Tag compare across all ways
  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      hit_vec[w] = valids[w] && (tags[w] == req_tag);
      if (hit_vec[w])
        hit_way = way_t'(w);
    end
  end

  assign hit = |hit_vec;

  //////////////////////////////////////////////////
  // Lookup FSM

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
        if (req)
          state_next = LOOKUP;
      LOOKUP:
        state_next = hit ? IDLE : WAIT_FILL;
      WAIT_FILL:
        if (fill_done)
          state_next = REPLAY;
      REPLAY:
        state_next = LOOKUP;
      default:
        state_next = IDLE;
    endcase
  end

  assign ok         = (state == LOOKUP) && hit;
  assign ins        = lines[hit_way][word_sel];
  assign touch      = ok;
  assign touch_way  = hit_way;
  assign fill_start = (state == LOOKUP) && !hit;
  assign miss_addr  = insaddr;
  assign miss       = fill_start || (state == WAIT_FILL);

  // A line lives in one way only
  a_single_hit: assert property (
    @(posedge clk) disable iff (rst) (state == LOOKUP) |-> $onehot0(hit_vec)
  );

endmodule

`default_nettype wire

//--- hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // Address fields and payload
  typedef logic [21:0] tag_t;
  typedef logic [3:0]  set_t;
  typedef logic [3:0]  word_idx_t;
  typedef logic [1:0]  way_t;
  typedef logic [31:0] word_t;
  typedef logic [1:0]  age_t;

  // Lookup FSM
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_FILL,
    REPLAY
  } ctrl_state_e;

  // Refill FSM
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_BEATS,
    FILL_COMMIT
  } fill_state_e;

endpackage

`default_nettype wire

//--- hw/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_top import icache_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  input  word_t insaddr,
  output word_t ins,
  output logic  ok,
  output logic  miss,
  output logic  sen,
  output word_t addr,
  input  logic  data_ok,
  input  word_t sdata
);

  set_t                    rd_set;
  tag_t                    way_tag [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] way_valid;
  word_t                   way_line [`ICACHE_WAYS][`ICACHE_LINE_WORDS];
  way_t                    victim;
  logic                    touch;
  way_t                    touch_way;
  logic                    fill_start;
  word_t                   miss_addr;
  logic                    fill_done;

  // Refill write bus, shared by all ways
  logic      wr_en;
  way_t      wr_way;
  set_t      wr_set;
  word_idx_t wr_word;
  word_t     wr_data;
  logic      tag_we;
  tag_t      wr_tag;
  logic      inval;

  for (genvar g = 0; g < `ICACHE_WAYS; g++)
  begin : g_way
    icache_way u_way (
      .clk      (clk),
      .rst      (rst),
      .rd_set   (rd_set),
      .rd_tag   (way_tag[g]),
      .rd_valid (way_valid[g]),
      .rd_line  (way_line[g]),
      .wr_en    (wr_en && (wr_way == way_t'(g))),
      .wr_set   (wr_set),
      .wr_word  (wr_word),
      .wr_data  (wr_data),
      .tag_we   (tag_we && (wr_way == way_t'(g))),
      .wr_tag   (wr_tag),
      .inval    (inval && (wr_way == way_t'(g)))
    );
  end

  lru_ages u_ages (
    .clk       (clk),
    .rst       (rst),
    .set       (rd_set),
    .valid     (way_valid),
    .touch     (touch),
    .touch_way (touch_way),
    .victim    (victim)
  );

  refill_unit u_refill (
    .clk        (clk),
    .rst        (rst),
    .fill_start (fill_start),
    .miss_addr  (miss_addr),
    .victim     (victim),
    .data_ok    (data_ok),
    .sdata      (sdata),
    .sen        (sen),
    .addr       (addr),
    .wr_en      (wr_en),
    .wr_way     (wr_way),
    .wr_set     (wr_set),
    .wr_word    (wr_word),
    .wr_data    (wr_data),
    .tag_we     (tag_we),
    .wr_tag     (wr_tag),
    .inval      (inval),
    .fill_done  (fill_done)
  );

  icache_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .insaddr    (insaddr),
    .rd_set     (rd_set),
    .tags       (way_tag),
    .valids     (way_valid),
    .lines      (way_line),
    .victim     (victim),
    .touch      (touch),
    .touch_way  (touch_way),
    .fill_start (fill_start),
    .miss_addr  (miss_addr),
    .fill_done  (fill_done),
    .ok         (ok),
    .ins        (ins),
    .miss       (miss)
  );

endmodule

`default_nettype wire

//--- hw/icache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_way import icache_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  set_t      rd_set,
  output tag_t      rd_tag,
  output logic      rd_valid,
  output word_t     rd_line [`ICACHE_LINE_WORDS],
  input  logic      wr_en,
  input  set_t      wr_set,
  input  word_idx_t wr_word,
  input  word_t     wr_data,
  input  logic      tag_we,
  input  tag_t      wr_tag,
  input  logic      inval
);

  tag_t                    tags [`ICACHE_SETS];
  word_t                   data [`ICACHE_SETS][`ICACHE_LINE_WORDS];
  logic [`ICACHE_SETS-1:0] valid;

  // Valid bits, set with the tag and dropped when a refill picks this way
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      valid <= '0;
    else if (tag_we)
      valid[wr_set] <= 1'b1;
    else if (inval)
      valid[wr_set] <= 1'b0;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      rd_valid <= 1'b0;
    else
      rd_valid <= valid[rd_set];
  end

  //////////////////////////////////////////////////
  // Tag and line storage

  always_ff @(posedge clk)
  begin
    if (tag_we)
      tags[wr_set] <= wr_tag;
    if (wr_en)
      data[wr_set][wr_word] <= wr_data;
  end

  // Whole line comes out, the controller picks the word
  always_ff @(posedge clk)
  begin
    rd_tag  <= tags[rd_set];
    rd_line <= data[rd_set];
  end

  // Commit and invalidate belong to different refill phases
  a_tag_inval_excl: assert property (
    @(posedge clk) disable iff (rst) !(tag_we && inval)
  );

endmodule

`default_nettype wire

//--- hw/lru_ages.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module lru_ages import icache_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  set_t                    set,
  input  logic [`ICACHE_WAYS-1:0] valid,
  input  logic                    touch,
  input  way_t                    touch_way,
  output way_t                    victim
);

  age_t ages [`ICACHE_WAYS][`ICACHE_SETS];
  age_t touched_age;

  assign touched_age = ages[touch_way][set];

  // Touched way becomes youngest and the ones not older than it age by one
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        for (int s = 0; s < `ICACHE_SETS; s++)
          ages[w][s] <= '0;
      end
    end
    else if (touch)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        if (way_t'(w) == touch_way)
          ages[w][set] <= '0;
        else if (ages[w][set] <= touched_age)
          ages[w][set] <= ages[w][set] + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Victim is the first empty way or else the oldest

  always_comb
  begin : pick_victim
    logic found;
    age_t oldest;
    found  = 1'b0;
    victim = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!valid[w] && !found)
      begin
        victim = way_t'(w);
        found  = 1'b1;
      end
    end
    oldest = ages[0][set];
    for (int w = 1; w < `ICACHE_WAYS; w++)
    begin
      if (!found && ages[w][set] > oldest)
      begin
        victim = way_t'(w);
        oldest = ages[w][set];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/refill_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module refill_unit import icache_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      fill_start,
  input  word_t     miss_addr,
  input  way_t      victim,
  input  logic      data_ok,
  input  word_t     sdata,
  output logic      sen,
  output word_t     addr,
  output logic      wr_en,
  output way_t      wr_way,
  output set_t      wr_set,
  output word_idx_t wr_word,
  output word_t     wr_data,
  output logic      tag_we,
  output tag_t      wr_tag,
  output logic      inval,
  output logic      fill_done
);

  fill_state_e state;
  word_t       addr_q;
  way_t        way_q;
  word_idx_t   beat_cnt;
  logic        inval_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= FILL_IDLE;
      beat_cnt <= '0;
      inval_q  <= 1'b0;
    end
    else
    begin
      inval_q <= 1'b0;
      case (state)
        FILL_IDLE:
          if (fill_start)
          begin
            state    <= FILL_BEATS;
            beat_cnt <= '0;
            inval_q  <= 1'b1;
          end
        FILL_BEATS:
          if (data_ok)
          begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == word_idx_t'(`ICACHE_LINE_WORDS - 1))
              state <= FILL_COMMIT;
          end
        FILL_COMMIT:
          state <= FILL_IDLE;
        default:
          state <= FILL_IDLE;
      endcase
    end
  end

  // Missed address and chosen way, held for the whole burst
  always_ff @(posedge clk)
  begin
    if (state == FILL_IDLE && fill_start)
    begin
      addr_q <= miss_addr;
      way_q  <= victim;
    end
  end

  //////////////////////////////////////////////////
  // Memory side and write bus to the ways

  assign sen  = (state == FILL_BEATS);
  assign addr = {addr_q[31:2], 2'b00};

  // Burst begins at the missed word and wraps inside the line
  assign wr_word = addr_q[`ICACHE_WORD_LSB +: `ICACHE_WORD_W] + beat_cnt;

  assign wr_en     = sen && data_ok;
  assign wr_data   = sdata;
  assign wr_way    = way_q;
  assign wr_set    = addr_q[`ICACHE_SET_LSB +: `ICACHE_SET_W];
  assign wr_tag    = addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
  assign inval     = inval_q;
  assign tag_we    = (state == FILL_COMMIT);
  assign fill_done = (state == FILL_COMMIT);

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst) fill_start |-> state == FILL_IDLE
  );

endmodule

`default_nettype wire
